// File: verification/dcache_trace.txt
# op addr wdata byte_en exp_rdata exp_miss
# exp_rdata is checked on reads only, exp_miss 1 means one refill burst
R 00000000 00000000 0 A5A50000 1
R 00000000 00000000 0 A5A50000 0
R 00000004 00000000 0 A5A50001 0
W 00000008 11223344 5 00000000 0
R 00000008 00000000 0 A5220044 0
R 00000080 00000000 0 A5A50020 1
R 00000104 00000000 0 A5A50041 1
R 00000008 00000000 0 A5220044 1
R 00000020 00000000 0 A5A50008 1
R 000000A0 00000000 0 A5A50028 1
R 00000024 00000000 0 A5A50009 0
R 00000120 00000000 0 A5A50048 1
R 00000020 00000000 0 A5A50008 0
R 000000A0 00000000 0 A5A50028 1
W 0000003C DEADBEEF F 00000000 0
R 0000003C 00000000 0 DEADBEEF 0
W 00000184 CAFEF00D 3 00000000 1
R 00000184 00000000 0 A5A5F00D 0
R 00000000 00000000 0 A5A50000 0
R 00000200 00000000 0 A5A50080 1
R 00000184 00000000 0 A5A5F00D 1

// File: flist.f
rtl/dcache_pkg.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

// File: verification/dcache_tb.sv
// ==============================
// Testbench of the data cache
// Replays verification/dcache_trace.txt, run from the project root
// Each request is held until busy is low ahead of a rising edge
// ==============================
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int clk_period     = 100;
    localparam int words_per_line = 8;
    localparam int max_ops        = 64;

    logic                 clk;
    logic                 rst_n;
    cpu_req_t             cpu_req;
    mem_req_t             mem_req;
    mem_rsp_t             mem_rsp;
    logic [data_bits-1:0] read_data;
    logic                 busy;
    logic                 wb_fault;

    // Trace contents
    logic                 op_write [max_ops];
    logic [addr_bits-1:0] op_addr  [max_ops];
    logic [data_bits-1:0] op_wdata [max_ops];
    logic [3:0]           op_be    [max_ops];
    logic [data_bits-1:0] op_rdata [max_ops];
    logic                 op_miss  [max_ops];
    int                   num_ops;
    logic                 trace_loaded = 1'b0;
    int unsigned          ar_count;

    dcache_top dcache_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .mem_rsp   (mem_rsp),
        .read_data (read_data),
        .busy      (busy),
        .mem_req   (mem_req)
    );

    dcache_mem_model #(
        .words_per_line (words_per_line)
    ) mem_model_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .wb_fault (wb_fault)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Refill bursts started, one per miss
    always @(posedge clk) begin
        if (!rst_n) begin
            ar_count <= 0;
        end else if (mem_req.ar_valid && mem_rsp.ar_ready) begin
            ar_count <= ar_count + 1;
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            assert (!wb_fault) else stop_run("Memory model received a malformed write-back burst");
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_run($sformatf("[ERROR] %s expected 0x%h, got 0x%h", name, expected, actual));
    endtask

    // ==============================
    // Trace loading
    // ==============================
    task automatic load_trace();
        int                fd;
        int                code;
        logic [8*8-1:0]    token;
        logic [8*128-1:0]  rest;
        logic [31:0]       f_addr;
        logic [31:0]       f_wdata;
        logic [31:0]       f_be;
        logic [31:0]       f_rdata;
        logic [31:0]       f_miss;
        num_ops = 0;
        fd = $fopen("verification/dcache_trace.txt", "r");
        if (fd == 0) begin
            stop_run("Cannot open the trace file verification/dcache_trace.txt");
        end else begin
            code = $fscanf(fd, "%s", token);
            while (code == 1) begin
                if (token == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h", f_addr, f_wdata, f_be, f_rdata, f_miss);
                    if (code != 5 || (token != "R" && token != "W") || num_ops >= max_ops) begin
                        stop_run("Malformed line in the trace file");
                    end else begin
                        op_write[num_ops] = (token == "W");
                        op_addr[num_ops]  = f_addr;
                        op_wdata[num_ops] = f_wdata;
                        op_be[num_ops]    = f_be[3:0];
                        op_rdata[num_ops] = f_rdata;
                        op_miss[num_ops]  = f_miss[0];
                        num_ops++;
                    end
                end
                code = $fscanf(fd, "%s", token);
            end
            $fclose(fd);
            trace_loaded = 1'b1;
        end
    endtask

    task automatic check_idle();
        logic [4:0] mem_bits;
        mem_bits = {mem_req.ar_valid, mem_req.aw_valid, mem_req.w_valid,
                    mem_req.b_ready, mem_req.r_ready};
        assert (busy == 1'b0) else report_mismatch("busy", 32'h0, {31'h0, busy});
        assert (mem_bits == 5'b0) else report_mismatch("mem_req valid/ready", 32'h0,
                                                       {27'h0, mem_bits});
    endtask

    // Starts and ends on a falling edge
    task automatic run_op(input int i);
        int unsigned          ar_start;
        int unsigned          ar_seen;
        logic [data_bits-1:0] sampled_data;
        cpu_req.read    = !op_write[i];
        cpu_req.write   = op_write[i];
        cpu_req.addr    = op_addr[i];
        cpu_req.wdata   = op_wdata[i];
        cpu_req.byte_en = op_be[i];
        ar_start        = ar_count;
        #(clk_period / 4);
        while (busy) begin
            @(negedge clk);
            #(clk_period / 4);
        end
        sampled_data = read_data;
        @(negedge clk);
        ar_seen = ar_count - ar_start;
        if (!op_write[i]) begin
            assert (sampled_data == op_rdata[i])
                else report_mismatch("read_data", op_rdata[i], sampled_data);
        end
        assert (ar_seen == {31'h0, op_miss[i]})
            else report_mismatch("ar transfers", {31'h0, op_miss[i]}, ar_seen);
    endtask

    initial begin
        cpu_req = '0;
        rst_n   = 1'b0;
        load_trace();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_idle();
        for (int i = 0; i < num_ops; i++) begin
            run_op(i);
        end
        cpu_req = '0;
        @(negedge clk);
        check_idle();
        $display("NO ERRORS");
        $finish;
    end

    // Watchdog, 400 cycles per trace line
    initial begin
        wait (trace_loaded);
        #(num_ops * 400 * clk_period);
        stop_run("Timeout, the cache did not finish the trace in time");
    end

endmodule

// File: verification/dcache_mem_model.sv
// ==============================
// Behavioral main memory for the cache testbench
// Covers mem_words words from address 0, word i starts as i ^ 32'hA5A5_0000
// Ready and valid signals stall at random from a fixed seed
// Raises wb_fault on a malformed write-back burst
// ==============================
`timescale 1ns/1ps

module dcache_mem_model
    import dcache_pkg::*;
#(
    parameter int words_per_line = 8,
    parameter int mem_words      = 1024
) (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp,
    output logic     wb_fault
);

    localparam int index_bits = $clog2(mem_words);

    logic [data_bits-1:0]  mem [mem_words];
    integer                seed = 33371;
    logic [index_bits-1:0] rd_index;
    int                    rd_left;
    logic [index_bits-1:0] wr_index;
    int                    wr_beats;
    logic                  wr_open;
    logic                  b_pending;

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = i ^ 32'hA5A5_0000;
        end
        mem_rsp  = '0;
        wb_fault = 1'b0;
    end

    // Go ahead in about two cycles of three
    function automatic logic pick();
        return ($unsigned($random(seed)) % 3) != 0;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            mem_rsp   <= '0;
            rd_left   <= 0;
            wr_open   <= 1'b0;
            wr_beats  <= 0;
            b_pending <= 1'b0;
            wb_fault  <= 1'b0;
        end else begin
            mem_rsp.ar_ready <= pick() && (rd_left == 0);
            mem_rsp.aw_ready <= pick() && !wr_open && !b_pending;
            mem_rsp.w_ready  <= pick() && wr_open;

            // ==============================
            // Refill burst
            // ==============================
            if (mem_req.ar_valid && mem_rsp.ar_ready) begin
                rd_index <= mem_req.ar_addr[byte_offset_bits +: index_bits];
                rd_left  <= words_per_line;
            end
            // Valid stays up until the beat is taken
            if (mem_rsp.r_valid && mem_req.r_ready) begin
                rd_index        <= rd_index + 1'b1;
                rd_left         <= rd_left - 1;
                mem_rsp.r_valid <= 1'b0;
                mem_rsp.r_last  <= 1'b0;
            end else if (!mem_rsp.r_valid && rd_left > 0 && pick()) begin
                mem_rsp.r_valid <= 1'b1;
                mem_rsp.r_data  <= mem[rd_index];
                mem_rsp.r_last  <= (rd_left == 1);
            end

            // ==============================
            // Write-back burst
            // ==============================
            if (mem_req.aw_valid && mem_rsp.aw_ready) begin
                wr_open  <= 1'b1;
                wr_index <= mem_req.aw_addr[byte_offset_bits +: index_bits];
                wr_beats <= 0;
                if ((mem_req.aw_addr & (4 * words_per_line - 1)) != 0) begin
                    wb_fault <= 1'b1;
                end
            end
            if (mem_req.w_valid && mem_rsp.w_ready) begin
                mem[wr_index] <= mem_req.w_data;
                wr_index      <= wr_index + 1'b1;
                wr_beats      <= wr_beats + 1;
                // w_last must mark exactly the final word
                if (!wr_open || (mem_req.w_last != (wr_beats == words_per_line - 1))) begin
                    wb_fault <= 1'b1;
                end
                if (mem_req.w_last) begin
                    wr_open   <= 1'b0;
                    b_pending <= 1'b1;
                end
            end
            if (mem_rsp.b_valid && mem_req.b_ready) begin
                mem_rsp.b_valid <= 1'b0;
                b_pending       <= 1'b0;
            end else if (b_pending && !mem_rsp.b_valid && pick()) begin
                mem_rsp.b_valid <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/dcache_top.sv
// ==============================
// Two-way write-back data cache
// Read hits answer in the same cycle
// Misses stall the core through busy
// ==============================
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int words_per_line = 8,
    parameter int num_sets       = 4,
    localparam int word_off_bits = $clog2(words_per_line),
    localparam int set_bits      = $clog2(num_sets),
    localparam int tag_bits      = addr_bits - set_bits - word_off_bits - byte_offset_bits
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cpu_req_t             cpu_req,
    input  mem_rsp_t             mem_rsp,
    output logic [data_bits-1:0] read_data,
    output logic                 busy,
    output mem_req_t             mem_req
);

    // Tag store results
    logic                     hit;
    logic                     hit_way;
    logic                     victim_way;
    logic                     victim_dirty;
    logic [tag_bits-1:0]      victim_tag;

    // Controller strobes
    logic                     touch;
    logic                     hit_write;
    logic                     fill_we;
    logic                     fill_done;
    logic                     fill_way;
    logic [word_off_bits-1:0] word_ptr;
    logic [data_bits-1:0]     line_word;

    dcache_ctrl #(
        .words_per_line (words_per_line),
        .num_sets       (num_sets)
    ) ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .hit          (hit),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .line_word    (line_word),
        .mem_rsp      (mem_rsp),
        .mem_req      (mem_req),
        .busy         (busy),
        .touch        (touch),
        .hit_write    (hit_write),
        .fill_we      (fill_we),
        .fill_done    (fill_done),
        .fill_way     (fill_way),
        .word_ptr     (word_ptr)
    );

    dcache_tag_store #(
        .words_per_line (words_per_line),
        .num_sets       (num_sets)
    ) tag_store_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr         (cpu_req.addr),
        .touch        (touch),
        .hit_write    (hit_write),
        .fill_done    (fill_done),
        .fill_way     (fill_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    // Refill data comes straight from the r channel
    dcache_data_store #(
        .words_per_line (words_per_line),
        .num_sets       (num_sets)
    ) data_store_i (
        .clk       (clk),
        .cpu_req   (cpu_req),
        .hit_way   (hit_way),
        .hit_write (hit_write),
        .fill_we   (fill_we),
        .fill_way  (fill_way),
        .word_ptr  (word_ptr),
        .fill_data (mem_rsp.r_data),
        .read_data (read_data),
        .line_word (line_word)
    );

endmodule

// File: rtl/dcache_ctrl.sv
// ==============================
// Miss FSM: write-back of a dirty victim, then line refill
// Write responses are taken as OK
// The core must hold its request while busy is high
// ==============================
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int words_per_line = 8,
    parameter int num_sets       = 4,
    localparam int word_off_bits = $clog2(words_per_line),
    localparam int set_bits      = $clog2(num_sets),
    localparam int tag_bits      = addr_bits - set_bits - word_off_bits - byte_offset_bits
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_req_t                 cpu_req,
    input  logic                     hit,
    input  logic                     victim_way,
    input  logic                     victim_dirty,
    input  logic [tag_bits-1:0]      victim_tag,
    input  logic [data_bits-1:0]     line_word,
    input  mem_rsp_t                 mem_rsp,
    output mem_req_t                 mem_req,
    output logic                     busy,
    output logic                     touch,
    output logic                     hit_write,
    output logic                     fill_we,
    output logic                     fill_done,
    output logic                     fill_way,
    output logic [word_off_bits-1:0] word_ptr
);

    localparam logic [word_off_bits-1:0] last_word = word_off_bits'(words_per_line - 1);

    cache_state_e             state;
    cache_state_e             next_state;
    logic                     next_fill_way;
    logic [word_off_bits-1:0] next_word_ptr;
    logic                     access;
    logic                     in_idle;
    logic [tag_bits-1:0]      req_tag;
    logic [set_bits-1:0]      req_set;

    assign req_tag = cpu_req.addr[addr_bits-1 -: tag_bits];
    assign req_set = cpu_req.addr[byte_offset_bits + word_off_bits +: set_bits];
    assign access  = cpu_req.read || cpu_req.write;
    assign in_idle = (state == IDLE);

    // ==============================
    // Core side
    // ==============================
    assign busy      = !in_idle || (access && !hit);
    assign touch     = in_idle && access && hit;
    assign hit_write = in_idle && cpu_req.write && hit;

    // Refill beats go straight into the data store
    assign fill_we   = (state == FILL_DATA) && mem_rsp.r_valid;
    assign fill_done = fill_we && mem_rsp.r_last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            fill_way <= 1'b0;
            word_ptr <= '0;
        end else begin
            state    <= next_state;
            fill_way <= next_fill_way;
            word_ptr <= next_word_ptr;
        end
    end

    // ==============================
    // Next state and memory channels
    // ==============================
    always_comb begin
        next_state    = state;
        next_fill_way = fill_way;
        next_word_ptr = word_ptr;

        mem_req         = '0;
        mem_req.ar_addr = {req_tag, req_set, {(word_off_bits + byte_offset_bits){1'b0}}};
        mem_req.aw_addr = {victim_tag, req_set, {(word_off_bits + byte_offset_bits){1'b0}}};
        mem_req.w_data  = line_word;

        unique case (state)
            IDLE: begin
                if (access && !hit) begin
                    next_fill_way = victim_way;
                    next_word_ptr = '0;
                    if (victim_dirty) begin
                        next_state = WB_ADDR;
                    end else begin
                        next_state = FILL_ADDR;
                    end
                end
            end
            WB_ADDR: begin
                mem_req.aw_valid = 1'b1;
                if (mem_rsp.aw_ready) begin
                    next_state = WB_DATA;
                end
            end
            WB_DATA: begin
                mem_req.w_valid = 1'b1;
                mem_req.w_last  = (word_ptr == last_word);
                if (mem_rsp.w_ready) begin
                    next_word_ptr = word_ptr + 1'b1;
                    if (mem_req.w_last) begin
                        next_state = WB_RESP;
                    end
                end
            end
            WB_RESP: begin
                mem_req.b_ready = 1'b1;
                if (mem_rsp.b_valid) begin
                    next_state = FILL_ADDR;
                end
            end
            FILL_ADDR: begin
                mem_req.ar_valid = 1'b1;
                if (mem_rsp.ar_ready) begin
                    next_word_ptr = '0;
                    next_state    = FILL_DATA;
                end
            end
            FILL_DATA: begin
                mem_req.r_ready = 1'b1;
                if (mem_rsp.r_valid) begin
                    next_word_ptr = word_ptr + 1'b1;
                    if (mem_rsp.r_last) begin
                        next_state = IDLE;
                    end
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Core contract
    a_no_read_and_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(cpu_req.read && cpu_req.write));

    a_req_held_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |=> $stable(cpu_req));

    a_w_last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.w_last |-> mem_req.w_valid);

endmodule

// File: rtl/dcache_data_store.sv
// ==============================
// Line data of both ways, no reset
// Hit writes and refill beats never share a cycle
// ==============================
`timescale 1ns/1ps

module dcache_data_store
    import dcache_pkg::*;
#(
    parameter int words_per_line = 8,
    parameter int num_sets       = 4,
    localparam int word_off_bits = $clog2(words_per_line),
    localparam int set_bits      = $clog2(num_sets)
) (
    input  logic                     clk,
    input  cpu_req_t                 cpu_req,
    input  logic                     hit_way,
    input  logic                     hit_write,
    input  logic                     fill_we,
    input  logic                     fill_way,
    input  logic [word_off_bits-1:0] word_ptr,
    input  logic [data_bits-1:0]     fill_data,
    output logic [data_bits-1:0]     read_data,
    output logic [data_bits-1:0]     line_word
);

    logic [data_bits-1:0] lines [num_ways][num_sets][words_per_line];

    logic [set_bits-1:0]      req_set;
    logic [word_off_bits-1:0] req_word;
    logic [data_bits-1:0]     byte_mask;
    logic [data_bits-1:0]     hit_word;

    assign req_set  = cpu_req.addr[byte_offset_bits + word_off_bits +: set_bits];
    assign req_word = cpu_req.addr[byte_offset_bits +: word_off_bits];

    // Expand byte enables to a bit mask
    always_comb begin
        for (int b = 0; b < data_bits / 8; b++) begin
            byte_mask[8*b +: 8] = {8{cpu_req.byte_en[b]}};
        end
    end

    assign hit_word  = lines[hit_way][req_set][req_word];
    assign read_data = hit_word;

    // Write-back source, walks the victim line
    assign line_word = lines[fill_way][req_set][word_ptr];

    always_ff @(posedge clk) begin
        if (hit_write) begin
            lines[hit_way][req_set][req_word] <=
                (hit_word & ~byte_mask) | (cpu_req.wdata & byte_mask);
        end else if (fill_we) begin
            lines[fill_way][req_set][word_ptr] <= fill_data;
        end
    end

endmodule

// File: rtl/dcache_tag_store.sv
// ==============================
// Tag, valid, dirty and LRU state of both ways
// words_per_line and num_sets must be powers of two, at least 2
// One LRU bit per set holds the index of the LRU way
// ==============================
`timescale 1ns/1ps

module dcache_tag_store
    import dcache_pkg::*;
#(
    parameter int words_per_line = 8,
    parameter int num_sets       = 4,
    localparam int word_off_bits = $clog2(words_per_line),
    localparam int set_bits      = $clog2(num_sets),
    localparam int tag_bits      = addr_bits - set_bits - word_off_bits - byte_offset_bits
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [addr_bits-1:0] addr,
    input  logic                 touch,
    input  logic                 hit_write,
    input  logic                 fill_done,
    input  logic                 fill_way,
    output logic                 hit,
    output logic                 hit_way,
    output logic                 victim_way,
    output logic                 victim_dirty,
    output logic [tag_bits-1:0]  victim_tag
);

    logic [tag_bits-1:0] tags  [num_ways][num_sets];
    logic                valid [num_ways][num_sets];
    logic                dirty [num_ways][num_sets];
    logic                lru   [num_sets];

    logic [tag_bits-1:0] req_tag;
    logic [set_bits-1:0] req_set;
    logic [num_ways-1:0] way_hit;

    assign req_tag = addr[addr_bits-1 -: tag_bits];
    assign req_set = addr[byte_offset_bits + word_off_bits +: set_bits];

    // ==============================
    // Lookup
    // ==============================
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = valid[w][req_set] && (tags[w][req_set] == req_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // Victim is whatever the LRU bit points at
    assign victim_way   = lru[req_set];
    assign victim_dirty = valid[victim_way][req_set] && dirty[victim_way][req_set];
    assign victim_tag   = tags[victim_way][req_set];

    // ==============================
    // Update
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < num_ways; w++) begin
                for (int s = 0; s < num_sets; s++) begin
                    tags[w][s]  <= '0;
                    valid[w][s] <= 1'b0;
                    dirty[w][s] <= 1'b0;
                end
            end
            for (int s = 0; s < num_sets; s++) begin
                lru[s] <= 1'b0;
            end
        end else begin
            if (touch) begin
                lru[req_set] <= ~hit_way;
            end
            if (hit_write) begin
                dirty[hit_way][req_set] <= 1'b1;
            end
            // New line arrives clean, other way becomes LRU
            if (fill_done) begin
                tags[fill_way][req_set]  <= req_tag;
                valid[fill_way][req_set] <= 1'b1;
                dirty[fill_way][req_set] <= 1'b0;
                lru[req_set]             <= ~fill_way;
            end
        end
    end

    // A line lives in one way only, so a refill never duplicates a tag
    a_single_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
        !(way_hit[0] && way_hit[1]));

endmodule

// File: rtl/dcache_pkg.sv
// ==============================
// Shared widths and types of the two-way data cache
// Way count is fixed at two, the LRU logic needs it
// Memory bursts always move one whole line
// ==============================
package dcache_pkg;

    // Fixed geometry
    localparam int num_ways         = 2;
    localparam int addr_bits        = 32;
    localparam int data_bits        = 32;
    localparam int byte_offset_bits = 2;

    // Miss handling FSM
    typedef enum logic [2:0] {
        IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP,
        FILL_ADDR,
        FILL_DATA
    } cache_state_e;

    // Core request, held until busy is low
    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [addr_bits-1:0]   addr;
        logic [data_bits-1:0]   wdata;
        logic [data_bits/8-1:0] byte_en;
    } cpu_req_t;

    // Cache toward main memory
    typedef struct packed {
        logic                 ar_valid;
        logic [addr_bits-1:0] ar_addr;
        logic                 aw_valid;
        logic [addr_bits-1:0] aw_addr;
        logic                 w_valid;
        logic [data_bits-1:0] w_data;
        logic                 w_last;
        logic                 b_ready;
        logic                 r_ready;
    } mem_req_t;

    // Main memory back to the cache
    typedef struct packed {
        logic                 ar_ready;
        logic                 aw_ready;
        logic                 w_ready;
        logic                 b_valid;
        logic                 r_valid;
        logic [data_bits-1:0] r_data;
        logic                 r_last;
    } mem_rsp_t;

endpackage
